/* hw/l2_write_pkg.sv */
`default_nettype none

package l2_write_pkg;

    //////////////////////////////
    // Memory write channel
    //////////////////////////////

    // One request word toward memory.
    // The address is taken once per burst on waddrOK, and each beat on wready.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;  // Byte enables.
        logic [7:0]  len;   // Beats minus one.
        logic        valid;
        logic        last;  // Final beat.
    } mem_w_t;

    // Handshake levels coming back from memory.
    typedef struct packed {
        logic waddrOK;  // Address accepted.
        logic wready;   // Beat accepted.
        logic bvalid;   // Write response, held until bready.
    } mem_w_rsp_t;

    //////////////////////////////
    // Arbiter FSM
    //////////////////////////////

    // Line writes go through wrt_w.
    // DMA writes walk dma_aw, dma_w, dma_r.
    typedef enum logic [2:0] {
        idle   = 3'd0,
        wrt_w  = 3'd1,
        dma_aw = 3'd2,
        dma_w  = 3'd3,
        dma_r  = 3'd4
    } arb_state_t;

endpackage

`default_nettype wire

/* hw/write_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module write_buffer #(
    parameter int offset_width = 2
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire logic                                buf_req,
    input  wire logic [31:0]                         buf_addr,
    input  wire logic [(1 << offset_width)*32-1:0]   buf_data,
    output logic                                     buf_ack,
    output logic                                     buf_idle,
    output l2_write_pkg::mem_w_t                     buf_w,
    input  l2_write_pkg::mem_w_rsp_t                 buf_rsp,
    output logic                                     buf_bready
);
    import l2_write_pkg::*;

    localparam int unsigned words     = 1 << offset_width;
    localparam int unsigned line_bits = words * 32;
    localparam logic [7:0]  burst_len = 8'(words - 1);

    //////////////////////////////
    // Line storage
    //////////////////////////////

    logic [line_bits-1:0]    line_q;
    logic [31:0]             addr_q;

    logic                    busy;      // A line is held.
    logic                    aw_done;   // Address taken by memory.
    logic                    resp_wait; // All beats sent, waiting on bvalid.
    logic [offset_width-1:0] beat_cnt;

    logic                    beat_go;
    logic                    final_beat;

    assign buf_ack    = buf_req && !busy;  // Accept only when empty.
    assign buf_idle   = !busy;
    assign buf_bready = resp_wait;

    assign final_beat = (beat_cnt == '1);
    assign beat_go    = buf_w.valid && buf_rsp.wready;

    always_ff @(posedge clk) begin
        if (buf_ack) begin
            line_q <= buf_data;
            addr_q <= buf_addr;
        end
    end

    //////////////////////////////
    // Burst control
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy      <= 1'b0;
            aw_done   <= 1'b0;
            resp_wait <= 1'b0;
            beat_cnt  <= '0;
        end else if (buf_ack) begin
            busy      <= 1'b1;
            aw_done   <= 1'b0;
            resp_wait <= 1'b0;
            beat_cnt  <= '0;
        end else if (busy) begin
            if (buf_w.valid && buf_rsp.waddrOK) begin
                aw_done <= 1'b1;
            end
            if (beat_go) begin
                if (final_beat) begin
                    resp_wait <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + offset_width'(1);
                end
            end
            if (resp_wait && buf_rsp.bvalid) begin
                busy      <= 1'b0;  // Idle again next cycle.
                resp_wait <= 1'b0;
            end
        end
    end

    always_comb begin
        buf_w       = '0;
        buf_w.valid = busy && !resp_wait;
        if (buf_w.valid) begin
            buf_w.addr = aw_done ? 32'd0 : addr_q;
            buf_w.data = line_q[beat_cnt*32 +: 32];
            buf_w.strb = 4'hF;  // Whole words only.
            buf_w.len  = burst_len;
            buf_w.last = final_beat;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // After the last beat goes out the channel falls quiet and waits for the response.
    a_last_closes_burst : assert property (
        @(posedge clk) disable iff (!rstn)
        (beat_go && buf_w.last) |=> (!buf_w.valid && buf_bready)
    );

    // An accepted line opens its burst next cycle with the captured address.
    a_accept_starts_burst : assert property (
        @(posedge clk) disable iff (!rstn)
        buf_ack |=> (!buf_idle && buf_w.valid && buf_w.addr == $past(buf_addr))
    );

endmodule

`default_nettype wire

/* hw/write_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module write_arbiter #(
    parameter int offset_width = 2
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    // Cache side.
    input  wire logic [31:0]                         line_addr,
    input  wire logic [(1 << offset_width)*32-1:0]   line_data,
    input  wire logic                                write_req,
    input  wire logic                                dma_sign,
    input  wire logic [3:0]                          dma_wstrb,
    output logic                                     write_ack,
    // Write buffer side.
    output logic                                     buf_req,
    output logic [31:0]                              buf_addr,
    output logic [(1 << offset_width)*32-1:0]        buf_data,
    input  wire logic                                buf_ack,
    input  wire logic                                buf_idle,
    input  l2_write_pkg::mem_w_t                     buf_w,
    output l2_write_pkg::mem_w_rsp_t                 buf_rsp,
    input  wire logic                                buf_bready,
    // Memory side.
    output l2_write_pkg::mem_w_t                     mem_w,
    input  l2_write_pkg::mem_w_rsp_t                 mem_rsp,
    output logic                                     bready
);
    import l2_write_pkg::*;

    arb_state_t state, state_nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        unique case (state)
            idle: begin
                if (write_req && !dma_sign) begin
                    state_nxt = wrt_w;
                end else if (write_req && buf_idle) begin
                    state_nxt = dma_aw;  // Hold off until the burst drains.
                end
            end
            wrt_w: if (buf_ack) state_nxt = idle;
            dma_aw: begin
                if (mem_rsp.waddrOK && mem_rsp.wready) begin
                    state_nxt = dma_r;
                end else if (mem_rsp.waddrOK) begin
                    state_nxt = dma_w;
                end
            end
            dma_w: if (mem_rsp.wready) state_nxt = dma_r;
            dma_r: if (mem_rsp.bvalid) state_nxt = idle;
            default: state_nxt = idle;
        endcase
    end

    //////////////////////////////
    // Outputs and channel mux
    //////////////////////////////

    always_comb begin
        write_ack = 1'b0;
        buf_req   = 1'b0;
        buf_addr  = '0;
        buf_data  = '0;
        mem_w     = buf_w;       // Buffer owns the channel by default.
        buf_rsp   = mem_rsp;
        bready    = buf_bready;
        unique case (state)
            wrt_w: begin
                buf_req   = write_req;
                buf_addr  = line_addr;
                buf_data  = line_data;
                write_ack = buf_ack;
            end
            dma_aw, dma_w, dma_r: begin
                buf_rsp    = '0;
                bready     = (state == dma_r);
                mem_w      = '0;
                mem_w.strb = dma_wstrb;
                if (state != dma_r) begin
                    mem_w.addr  = (state == dma_aw) ? line_addr : 32'd0;
                    mem_w.data  = line_data[31:0];
                    mem_w.valid = 1'b1;
                    mem_w.last  = 1'b1;  // Single beat, len stays 0.
                end
                write_ack = (state == dma_r) && mem_rsp.bvalid;
            end
            default: ;
        endcase
    end

    // The cache holds its request until acknowledged.
    a_ack_with_req : assert property (
        @(posedge clk) disable iff (!rstn)
        write_ack |-> write_req
    );

    // A DMA write never shares the channel with a buffer burst.
    a_dma_buf_idle : assert property (
        @(posedge clk) disable iff (!rstn)
        (state inside {dma_aw, dma_w, dma_r}) |-> buf_idle
    );

endmodule

`default_nettype wire

/* hw/l2_write_path.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_write_path #(
    parameter int offset_width = 2
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire logic [31:0]                         line_addr,
    input  wire logic [(1 << offset_width)*32-1:0]   line_data,
    input  wire logic                                write_req,
    input  wire logic                                dma_sign,
    input  wire logic [3:0]                          dma_wstrb,
    output logic                                     write_ack,
    output l2_write_pkg::mem_w_t                     mem_w,
    input  l2_write_pkg::mem_w_rsp_t                 mem_rsp,
    output logic                                     bready
);
    import l2_write_pkg::*;

    //////////////////////////////
    // Arbiter to buffer
    //////////////////////////////

    logic                                buf_req;
    logic [31:0]                         buf_addr;
    logic [(1 << offset_width)*32-1:0]   buf_data;
    logic                                buf_ack;
    logic                                buf_idle;
    mem_w_t                              buf_w;
    mem_w_rsp_t                          buf_rsp;
    logic                                buf_bready;

    write_arbiter #(
        .offset_width (offset_width)
    ) u_arb (
        .clk        (clk),
        .rstn       (rstn),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .write_req  (write_req),
        .dma_sign   (dma_sign),
        .dma_wstrb  (dma_wstrb),
        .write_ack  (write_ack),
        .buf_req    (buf_req),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .buf_ack    (buf_ack),
        .buf_idle   (buf_idle),
        .buf_w      (buf_w),
        .buf_rsp    (buf_rsp),
        .buf_bready (buf_bready),
        .mem_w      (mem_w),
        .mem_rsp    (mem_rsp),
        .bready     (bready)
    );

    write_buffer #(
        .offset_width (offset_width)
    ) u_buf (
        .clk        (clk),
        .rstn       (rstn),
        .buf_req    (buf_req),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .buf_ack    (buf_ack),
        .buf_idle   (buf_idle),
        .buf_w      (buf_w),
        .buf_rsp    (buf_rsp),
        .buf_bready (buf_bready)
    );

endmodule

`default_nettype wire

/* dv/mem_write_responder.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_write_responder (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  l2_write_pkg::mem_w_t     mem_w,
    output l2_write_pkg::mem_w_rsp_t mem_rsp,
    input  wire logic                bready,
    output logic [1:0]               fault  // Bit 0 bad last, bit 1 single beat inside a burst.
);
    import l2_write_pkg::*;

    typedef enum logic [1:0] {wait_addr, take_beats, send_resp} resp_state_t;

    logic [31:0] mem [256];
    resp_state_t st;
    logic [7:0]  widx, beat, len_q;

    function automatic logic random_ready();
        return ($urandom % 32'd4) != 32'd0;  // Roughly one stall cycle in four.
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hC0DE_0000 | 32'(i);
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            st      <= wait_addr;
            mem_rsp <= '0;
            widx    <= '0;
            beat    <= '0;
            len_q   <= '0;
            fault   <= '0;
        end else begin
            if (st != wait_addr && len_q != 8'd0 && mem_w.valid && mem_w.len == 8'd0) begin
                fault[1] <= 1'b1;
            end
            case (st)
                wait_addr: begin
                    mem_rsp.waddrOK <= mem_w.valid && !mem_rsp.waddrOK && random_ready();
                    if (mem_w.valid && mem_rsp.waddrOK) begin
                        widx  <= mem_w.addr[9:2];
                        len_q <= mem_w.len;
                        beat  <= '0;
                        st    <= take_beats;
                    end
                end
                take_beats: begin
                    mem_rsp.wready <= random_ready();
                    if (mem_w.valid && mem_rsp.wready) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_w.strb[b]) begin
                                mem[widx][b*8 +: 8] <= mem_w.data[b*8 +: 8];
                            end
                        end
                        if (mem_w.last != (beat == len_q)) begin
                            fault[0] <= 1'b1;
                        end
                        widx <= widx + 8'd1;
                        beat <= beat + 8'd1;
                        if (beat == len_q) begin
                            mem_rsp.wready <= 1'b0;
                            st             <= send_resp;
                        end
                    end
                end
                default: begin
                    // Response held until bready.
                    if (mem_rsp.bvalid && bready) begin
                        mem_rsp.bvalid <= 1'b0;
                        st             <= wait_addr;
                    end else if (!mem_rsp.bvalid) begin
                        mem_rsp.bvalid <= random_ready();
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* dv/tb_l2_write_path.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_l2_write_path;
    import l2_write_pkg::*;

    localparam int offset_width = 2;
    localparam int words        = 1 << offset_width;
    localparam int fields       = 3 + 2 * words;  // Kind, address, words, strobe, expected.
    localparam int max_writes   = 64;
    localparam int worst_cycles = 40;             // Per write.

    logic                clk = 1'b0;
    logic                rstn;
    logic                write_req;
    logic                dma_sign;
    logic [3:0]          dma_wstrb;
    logic [31:0]         line_addr;
    logic [words*32-1:0] line_data;
    logic                write_ack;
    logic                bready;
    mem_w_t              mem_w;
    mem_w_rsp_t          mem_rsp;
    logic [1:0]          mem_fault;
    logic [31:0]         stim [max_writes*fields];
    logic [31:0]         exp_mem [256];
    logic                touched [256];
    int                  n_writes;
    int                  cycle_limit;
    int                  cycles = 0;
    int                  acks = 0;

    l2_write_path #(.offset_width(offset_width)) dut (
        .clk, .rstn, .line_addr, .line_data, .write_req, .dma_sign, .dma_wstrb,
        .write_ack, .mem_w, .mem_rsp, .bready
    );

    mem_write_responder u_mem (.clk, .rstn, .mem_w, .mem_rsp, .bready, .fault(mem_fault));

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the writes did not all complete.", cycles);
            $display("Something failed");
            $fatal(1, "Run stopped on timeout.");
        end
    end

    // Channel rules, sampled away from the active edge.
    always @(negedge clk) begin
        if (rstn) begin
            check("responder fault", 32'd0, 32'(mem_fault));
            if (mem_w.valid && mem_w.len != 8'd0) begin
                check("burst len", 32'(words - 1), 32'(mem_w.len));
                check("burst strobe", 32'hF, 32'(mem_w.strb));
            end
            if (write_ack) begin
                check("ack without request", 32'd1, 32'(write_req));
                acks <= acks + 1;
            end
        end
    end

    task automatic send_write(input int e);
        int                  base;
        logic [7:0]          widx;
        logic [words*32-1:0] data;
        base = e * fields;
        widx = stim[base + 1][9:2];
        for (int w = 0; w < words; w++) begin
            data[w*32 +: 32] = stim[base + 2 + w];
        end
        @(posedge clk);
        line_addr <= stim[base + 1];
        line_data <= data;
        dma_sign  <= stim[base][0];
        dma_wstrb <= stim[base + 2 + words][3:0];
        write_req <= 1'b1;
        @(negedge clk);
        while (!write_ack) @(negedge clk);
        if (stim[base][0]) begin
            // DMA ack follows bvalid, so the word is already in memory.
            exp_mem[widx] = stim[base + 3 + words];
            touched[widx] = 1'b1;
            check($sformatf("dma write %0d", e), exp_mem[widx], u_mem.mem[widx]);
        end else begin
            for (int w = 0; w < words; w++) begin
                exp_mem[widx + 8'(w)] = stim[base + 3 + words + w];
                touched[widx + 8'(w)] = 1'b1;
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha802));
        rstn      = 1'b0;
        write_req = 1'b0;
        dma_sign  = 1'b0;
        dma_wstrb = '0;
        line_addr = '0;
        line_data = '0;
        foreach (stim[i]) stim[i] = '1;
        foreach (touched[i]) touched[i] = 1'b0;
        $readmemh("dv/write_input.txt", stim);
        n_writes = 0;
        while (n_writes < max_writes && stim[n_writes*fields] !== '1) n_writes++;
        cycle_limit = (n_writes + 1) * worst_cycles + 5;  // Extra slot drains the last burst.
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check("reset write_ack", 32'd0, 32'(write_ack));
        check("reset valid", 32'd0, 32'(mem_w.valid));
        check("reset bready", 32'd0, 32'(bready));
        for (int e = 0; e < n_writes; e++) send_write(e);
        @(posedge clk);
        write_req <= 1'b0;
        @(negedge clk);
        while (mem_w.valid || bready) @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            if (touched[i]) check($sformatf("final word %0d", i), exp_mem[i], u_mem.mem[i]);
        end
        check("ack count", 32'(n_writes), 32'(acks));
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/write_input.txt */
// kind addr word0 word1 word2 word3 strobe exp0 exp1 exp2 exp3 (hex)
// kind 0 is a line write, 1 is a DMA write of word0 under strobe, ffffffff ends the list
0 00000000 11111111 22222222 33333333 44444444 f 11111111 22222222 33333333 44444444
1 00000004 aabbccdd 00000000 00000000 00000000 3 2222ccdd 00000000 00000000 00000000
0 00000040 0a0b0c0d 1a1b1c1d 2a2b2c2d 3a3b3c3d f 0a0b0c0d 1a1b1c1d 2a2b2c2d 3a3b3c3d
0 00000080 deadbeef cafef00d 01234567 89abcdef f deadbeef cafef00d 01234567 89abcdef
1 00000100 12345678 00000000 00000000 00000000 8 12de0040 00000000 00000000 00000000
1 00000084 55667788 00000000 00000000 00000000 6 ca66770d 00000000 00000000 00000000
0 000000c0 00000001 00000002 00000003 00000004 f 00000001 00000002 00000003 00000004
0 00000040 10000000 20000000 30000000 40000000 f 10000000 20000000 30000000 40000000
1 00000048 ffffffff 00000000 00000000 00000000 f ffffffff 00000000 00000000 00000000
1 000001fc a1b2c3d4 00000000 00000000 00000000 1 c0de00d4 00000000 00000000 00000000
0 00000100 5a5a5a5a a5a5a5a5 0f0f0f0f f0f0f0f0 f 5a5a5a5a a5a5a5a5 0f0f0f0f f0f0f0f0
1 00000108 99999999 00000000 00000000 00000000 0 0f0f0f0f 00000000 00000000 00000000
1 0000010c 77665544 00000000 00000000 00000000 c 7766f0f0 00000000 00000000 00000000
0 000003f0 0badf00d 1badf00d 2badf00d 3badf00d f 0badf00d 1badf00d 2badf00d 3badf00d
1 00000000 00ab00cd 00000000 00000000 00000000 5 11ab11cd 00000000 00000000 00000000
0 00000200 13579bdf 2468ace0 fedcba98 76543210 f 13579bdf 2468ace0 fedcba98 76543210
1 00000204 11223344 00000000 00000000 00000000 a 116833e0 00000000 00000000 00000000
ffffffff

/* sources.f */
hw/l2_write_pkg.sv
hw/write_buffer.sv
hw/write_arbiter.sv
hw/l2_write_path.sv
dv/mem_write_responder.sv
dv/tb_l2_write_path.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_l2_write_path
./obj_dir/Vtb_l2_write_path | tee /dev/stderr | grep -qx "Everything OK"
